// ==== src/rx_format_pkg.sv ====
package rx_format_pkg;

    // Parallel lanes per code vector
    localparam int lane_count = 4;

    // Signed ADC code
    localparam int code_width = 8;

    // Equalizer estimate after shift and saturation
    localparam int est_width = 10;
    localparam int err_width = 10;

endpackage : rx_format_pkg

// ==== src/rx_filter_pkg.sv ====
package rx_filter_pkg;

    // Feed-forward equalizer, tap 0 is the lane's own sample
    localparam int ffe_taps        = 3;
    localparam int weight_width    = 8;
    localparam int ffe_shift_width = 4;
    localparam int thresh_width    = 10;

    // Channel estimate, tap 0 is the current bit
    localparam int chan_taps        = 2;
    localparam int chan_width       = 8;
    localparam int chan_shift_width = 3;

    // Full-precision accumulators
    localparam int ffe_acc_width   = rx_format_pkg::code_width + weight_width + $clog2(ffe_taps);
    localparam int chan_acc_width  = chan_width + $clog2(chan_taps) + 1;
    localparam int chan_diff_width = chan_acc_width + 1;

    localparam int bit_latency   = 2;
    localparam int error_latency = 3;

endpackage : rx_filter_pkg

// ==== src/adc_code_window.sv ====
`timescale 1ns/1ps

module adc_code_window
    import rx_format_pkg::*;
    import rx_filter_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic signed [code_width-1:0] adc_codes_i [lane_count],
    output logic signed [code_width-1:0] win_codes_o [lane_count][ffe_taps],
    output logic signed [code_width-1:0] dly_codes_o [lane_count]
);

    logic signed [code_width-1:0] cur_q  [lane_count];
    logic signed [code_width-1:0] prev_q [lane_count];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lane_count; i++) begin
                cur_q[i]  <= '0;
                prev_q[i] <= '0;
            end
        end else begin
            cur_q  <= adc_codes_i;
            prev_q <= cur_q;
        end
    end

    // Lane i tap t is the sample t unit intervals before lane i
    always_comb begin
        int src;
        for (int i = 0; i < lane_count; i++) begin
            for (int t = 0; t < ffe_taps; t++) begin
                src = (lane_count + i - t) % lane_count;
                if (i >= t) begin
                    win_codes_o[i][t] = cur_q[src];
                end else begin
                    // Crosses into the tail of the previous vector
                    win_codes_o[i][t] = prev_q[src];
                end
            end
        end
    end

    // Lines up with the bits one stage later
    assign dly_codes_o = prev_q;

endmodule : adc_code_window

// ==== src/ffe_slice_lane.sv ====
`timescale 1ns/1ps

module ffe_slice_lane
    import rx_format_pkg::*;
    import rx_filter_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic signed [code_width-1:0]      taps_i       [ffe_taps],
    input  logic signed [weight_width-1:0]    weights_i    [ffe_taps],
    input  logic        [ffe_taps-1:0]        tap_enable_i,
    input  logic        [ffe_shift_width-1:0] ffe_shift_i,
    input  logic signed [thresh_width-1:0]    thresh_i,
    output logic                              bit_o,
    output logic signed [est_width-1:0]       est_o
);

    logic signed [ffe_acc_width-1:0] acc;
    logic signed [ffe_acc_width-1:0] acc_shift;
    logic signed [est_width-1:0]     est_sat;
    logic                            bit_next;

    // Sum of enabled products
    always_comb begin
        acc = '0;
        for (int t = 0; t < ffe_taps; t++) begin
            if (tap_enable_i[t]) begin
                acc = acc + ffe_acc_width'(taps_i[t] * weights_i[t]);
            end
        end
    end

    assign acc_shift = acc >>> ffe_shift_i;

    // Clamp when the upper bits are not a pure sign extension
    always_comb begin
        logic [ffe_acc_width-est_width:0] upper;
        upper = acc_shift[ffe_acc_width-1:est_width-1];
        if ((&upper) || !(|upper)) begin
            est_sat = acc_shift[est_width-1:0];
        end else if (acc_shift[ffe_acc_width-1]) begin
            est_sat = {1'b1, {(est_width-1){1'b0}}};
        end else begin
            est_sat = {1'b0, {(est_width-1){1'b1}}};
        end
    end

    // Slicer, strictly above threshold
    assign bit_next = (est_sat > thresh_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_o <= 1'b0;
            est_o <= '0;
        end else begin
            bit_o <= bit_next;
            est_o <= est_sat;
        end
    end

endmodule : ffe_slice_lane

// ==== src/channel_error_unit.sv ====
`timescale 1ns/1ps

module channel_error_unit
    import rx_format_pkg::*;
    import rx_filter_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic        [lane_count-1:0]       bits_i,
    input  logic signed [code_width-1:0]       dly_codes_i [lane_count],
    input  logic signed [chan_width-1:0]       chan_coef_i [chan_taps],
    input  logic        [chan_shift_width-1:0] chan_shift_i,
    output logic signed [err_width-1:0]        est_error_o [lane_count]
);

    // Tail bits of the previous vector
    logic [chan_taps-2:0] prev_bits_q;

    // Oldest bit at index 0
    logic [lane_count+chan_taps-2:0] bit_hist;

    logic signed [chan_diff_width-1:0] diff    [lane_count];
    logic signed [err_width-1:0]       err_sat [lane_count];

    assign bit_hist = {bits_i, prev_bits_q};

    // Rebuild the expected code and subtract the received one
    always_comb begin
        logic signed [chan_acc_width-1:0] term;
        logic signed [chan_acc_width-1:0] sum;
        logic signed [chan_acc_width-1:0] est_code;
        for (int i = 0; i < lane_count; i++) begin
            sum = '0;
            for (int t = 0; t < chan_taps; t++) begin
                term = chan_acc_width'(chan_coef_i[t]);
                // Bit 0 stands for a -1 symbol
                if (!bit_hist[i + chan_taps - 1 - t]) begin
                    term = -term;
                end
                sum = sum + term;
            end
            est_code = sum >>> chan_shift_i;
            diff[i] = chan_diff_width'(est_code) - chan_diff_width'(dly_codes_i[i]);
        end
    end

    always_comb begin
        logic [chan_diff_width-err_width:0] upper;
        for (int i = 0; i < lane_count; i++) begin
            upper = diff[i][chan_diff_width-1:err_width-1];
            if ((&upper) || !(|upper)) begin
                err_sat[i] = diff[i][err_width-1:0];
            end else if (diff[i][chan_diff_width-1]) begin
                err_sat[i] = {1'b1, {(err_width-1){1'b0}}};
            end else begin
                err_sat[i] = {1'b0, {(err_width-1){1'b1}}};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_bits_q <= '0;
            for (int i = 0; i < lane_count; i++) begin
                est_error_o[i] <= '0;
            end
        end else begin
            prev_bits_q <= bits_i[lane_count-1 -: chan_taps-1];
            est_error_o <= err_sat;
        end
    end

endmodule : channel_error_unit

// ==== src/rx_dsp_top.sv ====
`timescale 1ns/1ps

module rx_dsp_top
    import rx_format_pkg::*;
    import rx_filter_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic signed [code_width-1:0]       adc_codes_i [lane_count],

    // Equalizer settings, shared by all lanes
    input  logic signed [weight_width-1:0]     weights_i   [ffe_taps],
    input  logic        [ffe_taps-1:0]         tap_enable_i,
    input  logic        [ffe_shift_width-1:0]  ffe_shift_i,
    input  logic signed [thresh_width-1:0]     thresh_i,

    // Channel estimate
    input  logic signed [chan_width-1:0]       chan_coef_i [chan_taps],
    input  logic        [chan_shift_width-1:0] chan_shift_i,

    output logic        [lane_count-1:0]       bits_o,
    output logic signed [est_width-1:0]        est_o       [lane_count],
    output logic signed [err_width-1:0]        est_error_o [lane_count]
);

    logic signed [code_width-1:0] win_codes [lane_count][ffe_taps];
    logic signed [code_width-1:0] dly_codes [lane_count];

    adc_code_window u_code_window (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .adc_codes_i (adc_codes_i),
        .win_codes_o (win_codes),
        .dly_codes_o (dly_codes)
    );

    for (genvar gi = 0; gi < lane_count; gi++) begin : g_lane
        ffe_slice_lane u_lane (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .taps_i       (win_codes[gi]),
            .weights_i    (weights_i),
            .tap_enable_i (tap_enable_i),
            .ffe_shift_i  (ffe_shift_i),
            .thresh_i     (thresh_i),
            .bit_o        (bits_o[gi]),
            .est_o        (est_o[gi])
        );
    end

    // Error stage consumes the registered lane bits
    channel_error_unit u_error_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .bits_i       (bits_o),
        .dly_codes_i  (dly_codes),
        .chan_coef_i  (chan_coef_i),
        .chan_shift_i (chan_shift_i),
        .est_error_o  (est_error_o)
    );

endmodule : rx_dsp_top

// ==== tb/rx_dsp_model.svh ====
`ifndef RX_DSP_MODEL_SVH
`define RX_DSP_MODEL_SVH

// Clamp to a signed field of the given width
function automatic int saturate(input int value, input int width);
    int hi;
    int lo;
    hi = (1 << (width - 1)) - 1;
    lo = -(1 << (width - 1));
    if (value > hi) begin
        return hi;
    end
    if (value < lo) begin
        return lo;
    end
    return value;
endfunction

// Sample t unit intervals before lane i, reaching into the previous vector
function automatic int window_sample(input int cur [lane_count], input int prev [lane_count],
                                     input int lane, input int tap);
    if (lane >= tap) begin
        return cur[lane - tap];
    end
    return prev[lane_count + lane - tap];
endfunction

function automatic int ffe_estimate(input int taps [ffe_taps], input int weights [ffe_taps],
                                    input logic [ffe_taps-1:0] tap_enable, input int shift);
    int acc;
    acc = 0;
    for (int t = 0; t < ffe_taps; t++) begin
        if (tap_enable[t]) begin
            acc += taps[t] * weights[t];
        end
    end
    return saturate(acc >>> shift, est_width);
endfunction

function automatic bit slice_bit(input int est, input int thresh);
    return est > thresh;
endfunction

// syms[0] is the lane's own bit, syms[1] the bit before it
function automatic int channel_error(input bit syms [chan_taps], input int coef [chan_taps],
                                     input int shift, input int code);
    int acc;
    acc = 0;
    for (int t = 0; t < chan_taps; t++) begin
        acc += syms[t] ? coef[t] : -coef[t];
    end
    return saturate((acc >>> shift) - code, err_width);
endfunction

`endif

// ==== tb/tb_rx_dsp.sv ====
`timescale 1ns/1ps

module tb_rx_dsp
    import rx_format_pkg::*;
    import rx_filter_pkg::*;
;

    `include "rx_dsp_model.svh"

    localparam int          clk_period      = 20;
    localparam int          reset_cycles    = 10;
    localparam int          idle_cycles     = 5;
    localparam int          unit_vectors    = 40;
    localparam int          rounds          = 8;
    localparam int          ffe_vectors     = 30;
    localparam int          enable_vectors  = 20;
    localparam int          chan_vectors    = 30;
    localparam int          stream_vectors  = 200;
    localparam int          drain_cycles    = error_latency + 1;
    localparam int          test_count      = 6;
    localparam int          watchdog_margin = 100;
    localparam int unsigned rand_seed       = 32'h195be7d7;

    localparam int total_cycles = reset_cycles + idle_cycles + unit_vectors
        + rounds * (ffe_vectors + 2) + (1 << ffe_taps) * enable_vectors
        + rounds * chan_vectors + stream_vectors + test_count * (drain_cycles + 1);

    logic                               clk = 1'b0;
    logic                               rst_n;
    logic signed [code_width-1:0]       adc_codes  [lane_count];
    logic signed [weight_width-1:0]     weights    [ffe_taps];
    logic        [ffe_taps-1:0]         tap_enable;
    logic        [ffe_shift_width-1:0]  ffe_shift;
    logic signed [thresh_width-1:0]     thresh;
    logic signed [chan_width-1:0]       chan_coef  [chan_taps];
    logic        [chan_shift_width-1:0] chan_shift;
    logic        [lane_count-1:0]       bits;
    logic signed [est_width-1:0]        est        [lane_count];
    logic signed [err_width-1:0]        est_error  [lane_count];

    // Expected outputs after the most recent rising edge
    logic        [lane_count-1:0]       exp_bits;
    logic signed [est_width-1:0]        exp_est    [lane_count];
    logic signed [err_width-1:0]        exp_err    [lane_count];
    logic                               last_bit;
    logic [lane_count*code_width-1:0]   code_q     [$];

    int error_count = 0;
    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;

    rx_dsp_top DUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .adc_codes_i  (adc_codes),
        .weights_i    (weights),
        .tap_enable_i (tap_enable),
        .ffe_shift_i  (ffe_shift),
        .thresh_i     (thresh),
        .chan_coef_i  (chan_coef),
        .chan_shift_i (chan_shift),
        .bits_o       (bits),
        .est_o        (est),
        .est_error_o  (est_error)
    );

    function automatic int lane_code(input logic [lane_count*code_width-1:0] word, input int lane);
        logic signed [code_width-1:0] code;
        code = word[lane*code_width +: code_width];
        return int'(code);
    endfunction

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // Model step, one vector per stage per edge
    always @(posedge clk) begin : model_step
        int                             cur   [lane_count];
        int                             prev  [lane_count];
        int                             taps  [ffe_taps];
        int                             wts   [ffe_taps];
        int                             coefs [chan_taps];
        bit                             syms  [chan_taps];
        logic [lane_count-1:0]          nxt_bits;
        logic [lane_count*code_width-1:0] word;
        int                             est_val;
        if (!rst_n) begin
            code_q.delete();
            code_q.push_back('0);
            code_q.push_back('0);
            exp_bits = '0;
            last_bit = 1'b0;
            for (int i = 0; i < lane_count; i++) begin
                exp_est[i] = '0;
                exp_err[i] = '0;
            end
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                cur[i]  = lane_code(code_q[1], i);
                prev[i] = lane_code(code_q[0], i);
                word[i*code_width +: code_width] = adc_codes[i];
            end
            for (int t = 0; t < ffe_taps; t++) begin
                wts[t] = int'(weights[t]);
            end
            for (int t = 0; t < chan_taps; t++) begin
                coefs[t] = int'(chan_coef[t]);
            end
            // Errors use the bits now on the outputs and their codes
            for (int i = 0; i < lane_count; i++) begin
                syms[0] = exp_bits[i];
                syms[1] = (i == 0) ? last_bit : exp_bits[i-1];
                exp_err[i] = err_width'(channel_error(syms, coefs, int'(chan_shift), prev[i]));
            end
            last_bit = exp_bits[lane_count-1];
            for (int i = 0; i < lane_count; i++) begin
                for (int t = 0; t < ffe_taps; t++) begin
                    taps[t] = window_sample(cur, prev, i, t);
                end
                est_val     = ffe_estimate(taps, wts, tap_enable, int'(ffe_shift));
                nxt_bits[i] = slice_bit(est_val, int'(thresh));
                exp_est[i]  = est_width'(est_val);
            end
            exp_bits = nxt_bits;
            code_q.push_back(word);
            code_q.delete(0);
        end
    end

    for (genvar gi = 0; gi < lane_count; gi++) begin : g_check
        assert property (@(negedge clk) bits[gi] == exp_bits[gi])
            else begin
                error_count++;
                $display("error: bits_o[%0d] expected %h got %h", gi, exp_bits[gi], bits[gi]);
            end
        assert property (@(negedge clk) est[gi] == exp_est[gi])
            else begin
                error_count++;
                $display("error: est_o[%0d] expected %h got %h", gi, exp_est[gi], est[gi]);
            end
        assert property (@(negedge clk) est_error[gi] == exp_err[gi])
            else begin
                error_count++;
                $display("error: est_error_o[%0d] expected %h got %h",
                         gi, exp_err[gi], est_error[gi]);
            end
    end

    task automatic drive_random_codes(input int count);
        repeat (count) begin
            for (int i = 0; i < lane_count; i++) begin
                adc_codes[i] = code_width'($urandom);
            end
            @(negedge clk);
        end
    endtask

    // Full-scale vectors of both polarities
    task automatic drive_extreme_codes();
        for (int i = 0; i < lane_count; i++) begin
            adc_codes[i] = {1'b0, {(code_width-1){1'b1}}};
        end
        @(negedge clk);
        for (int i = 0; i < lane_count; i++) begin
            adc_codes[i] = {1'b1, {(code_width-1){1'b0}}};
        end
        @(negedge clk);
    endtask

    task automatic pick_ffe_config();
        for (int t = 0; t < ffe_taps; t++) begin
            weights[t] = weight_width'($urandom);
        end
        tap_enable = '1;
        ffe_shift  = ffe_shift_width'($urandom_range(0, (1 << ffe_shift_width) - 1));
        thresh     = thresh_width'(int'($urandom_range(0, 200)) - 100);
    endtask

    task automatic pick_chan_config();
        for (int t = 0; t < chan_taps; t++) begin
            chan_coef[t] = chan_width'($urandom);
        end
        chan_shift = chan_shift_width'($urandom_range(0, (1 << chan_shift_width) - 1));
    endtask

    // Lets the last vectors reach the error stage before the tally
    task automatic close_test(input string name);
        repeat (drain_cycles) @(negedge clk);
        @(posedge clk);
        if (error_count == test_errors) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
        @(negedge clk);
    endtask

    initial begin
        #((total_cycles + watchdog_margin) * clk_period);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(rand_seed));
        rst_n      = 1'b0;
        tap_enable = '0;
        ffe_shift  = '0;
        thresh     = '0;
        chan_shift = '0;
        for (int i = 0; i < lane_count; i++) begin
            adc_codes[i] = '0;
        end
        for (int t = 0; t < ffe_taps; t++) begin
            weights[t] = '0;
        end
        for (int t = 0; t < chan_taps; t++) begin
            chan_coef[t] = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        repeat (idle_cycles) @(negedge clk);
        close_test("reset");

        // Pass-through: unit weight on the lane's own sample
        weights[0] = 8'sd1;
        tap_enable = '1;
        drive_random_codes(unit_vectors);
        close_test("unit_tap");

        for (int r = 0; r < rounds; r++) begin
            pick_ffe_config();
            if (r < rounds / 2) begin
                ffe_shift = ffe_shift_width'(r);
            end
            drive_extreme_codes();
            drive_random_codes(ffe_vectors);
        end
        close_test("random_ffe");

        for (int en = 0; en < (1 << ffe_taps); en++) begin
            pick_ffe_config();
            tap_enable = ffe_taps'(en);
            drive_random_codes(enable_vectors);
        end
        close_test("tap_enable");

        pick_ffe_config();
        for (int r = 0; r < rounds; r++) begin
            pick_chan_config();
            drive_random_codes(chan_vectors);
        end
        close_test("channel_error");

        pick_ffe_config();
        pick_chan_config();
        drive_random_codes(stream_vectors);
        close_test("stream");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_rx_dsp

// ==== rx_dsp.f ====
+incdir+tb
src/rx_format_pkg.sv
src/rx_filter_pkg.sv
src/adc_code_window.sv
src/ffe_slice_lane.sv
src/channel_error_unit.sv
src/rx_dsp_top.sv
tb/tb_rx_dsp.sv

// ==== Makefile ====
# Verilator flow for the receive DSP datapath

VERILATOR ?= verilator
TOP       ?= tb_rx_dsp
FILELIST  ?= rx_dsp.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
